// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= l2_cache_tb
RTL_TOP ?= l2_cache_top
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --timescale 1ns/1ps
LINT_FLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
+incdir+sim
rtl/l2_cache_cfg_pkg.sv
rtl/l2_cache_pipe_pkg.sv
rtl/l2_cache_lru.sv
rtl/l2_cache_tag.sv
rtl/l2_cache_match.sv
rtl/l2_cache_data.sv
rtl/l2_cache_response.sv
rtl/l2_cache_top.sv
sim/l2_cache_tb.sv

// ==== rtl/l2_cache_cfg_pkg.sv ====
// ==========================================================
// Cache geometry and request op codes.
// Four ways are fixed; the pLRU tree and way match assume it.
// Addresses count lines, so the set index is the low bits.
// ==========================================================
package l2_cache_cfg_pkg;

	localparam int offset_width = 6;
	localparam int line_bytes = 2 ** offset_width;
	localparam int line_bits = line_bytes * 8;
	localparam int num_ways = 4;
	localparam int way_width = 2;
	localparam int addr_width = 26;

	// Sized for any set index width; unused high bits stay zero.
	localparam int tag_field_width = addr_width;

	localparam logic [2:0] op_load = 3'd0;
	localparam logic [2:0] op_store = 3'd1;

endpackage

// ==== rtl/l2_cache_data.sv ====
`timescale 1ns/1ps
// ==========================================================
// Data stage. One line array per way, no bypass needed since
// writes land before the next request reaches this stage.
// A store fill lays its masked bytes over the fetched line.
// ==========================================================
module l2_cache_data
	import l2_cache_cfg_pkg::*, l2_cache_pipe_pkg::*;
	#(parameter int set_index_width = 6)
	(input logic clk,
	input logic reset,
	input logic stall_pipeline,
	input l2_match_rec_t match_rec,
	input logic [line_bits-1:0] fill_data,
	output l2_match_rec_t data_rec,
	output logic [line_bits-1:0] line);

	localparam int num_sets = 1 << set_index_width;

	logic [line_bits-1:0] line_mem [num_ways][num_sets];
	logic [set_index_width-1:0] set;
	logic is_store;
	logic do_write;
	logic [line_bits-1:0] base;
	logic [line_bits-1:0] merged;
	logic valid_q;
	l2_match_rec_t rec_q;

	assign set = match_rec.req.address[set_index_width-1:0];
	assign is_store = match_rec.req.op == op_store;
	assign do_write = match_rec.req.valid && match_rec.hit
		&& (match_rec.req.has_fill || is_store);
	assign base = match_rec.req.has_fill ? fill_data : line_mem[match_rec.way][set];

	always_comb
	begin
		merged = base;
		for (int b = 0; b < line_bytes; b++)
			if (is_store && match_rec.req.mask[b])
				merged[b * 8 +: 8] = match_rec.req.data[b * 8 +: 8];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			valid_q <= 1'b0;
		else if (!stall_pipeline)
			valid_q <= match_rec.req.valid;
	end

	always_ff @(posedge clk)
	begin
		if (!stall_pipeline)
		begin
			rec_q <= match_rec;
			line <= merged;	// Line as it stands after this request.
			if (do_write)
				line_mem[match_rec.way][set] <= merged;
		end
	end

	always_comb
	begin
		data_rec = rec_q;
		data_rec.req.valid = valid_q;
	end

endmodule

// ==== rtl/l2_cache_lru.sv ====
`timescale 1ns/1ps
// ==========================================================
// Tree pseudo-LRU for a four-way cache, three bits per set.
// The read is combinational; an update lands on the clock.
// ==========================================================
module l2_cache_lru
	#(parameter int set_index_width = 6)
	(input logic clk,
	input logic reset,
	input logic stall_pipeline,
	input logic [set_index_width-1:0] set,
	input logic update,
	input logic [set_index_width-1:0] update_set,
	input logic [1:0] update_way,
	output logic [1:0] lru_way);

	localparam int num_sets = 1 << set_index_width;

	// Bit 0 picks the pair, bit 1 splits ways 0/1, bit 2 ways 2/3.
	logic [num_sets-1:0][2:0] tree;
	logic [2:0] cur_bits;
	logic [2:0] new_bits;

	assign cur_bits = tree[set];
	assign lru_way = cur_bits[0] ? {1'b1, cur_bits[2]} : {1'b0, cur_bits[1]};

	always_comb
	begin
		new_bits = tree[update_set];
		new_bits[0] = ~update_way[1];	// Root points at the other pair.
		if (update_way[1])
			new_bits[2] = ~update_way[0];
		else
			new_bits[1] = ~update_way[0];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			tree <= '0;
		else if (update && !stall_pipeline)
			tree[update_set] <= new_bits;
	end

endmodule

// ==== rtl/l2_cache_match.sv ====
`timescale 1ns/1ps
// ==========================================================
// Way match stage. A fill counts as a hit in its fill way.
// The LRU is updated on the edge that registers the result.
// ==========================================================
module l2_cache_match
	import l2_cache_cfg_pkg::*, l2_cache_pipe_pkg::*;
	#(parameter int set_index_width = 6)
	(input logic clk,
	input logic reset,
	input logic stall_pipeline,
	input l2_tag_rec_t tag_rec,
	output l2_match_rec_t match_rec,
	output logic lru_update,
	output logic [set_index_width-1:0] lru_set,
	output logic [way_width-1:0] lru_way);

	logic [tag_field_width-1:0] req_tag;
	logic [num_ways-1:0] hits;
	l2_match_rec_t rec_next;
	logic valid_q;
	l2_match_rec_t rec_q;

	assign req_tag = tag_rec.req.address >> set_index_width;

	always_comb
	begin
		for (int w = 0; w < num_ways; w++)
			hits[w] = tag_rec.way_valid[w] && (tag_rec.tags[w] == req_tag);
		rec_next.req = tag_rec.req;
		rec_next.replace_way = tag_rec.replace_way;
		rec_next.hit = tag_rec.req.has_fill || (|hits);
		rec_next.way = '0;
		if (tag_rec.req.has_fill)
			rec_next.way = tag_rec.req.fill_way;
		else
			for (int w = 0; w < num_ways; w++)
				if (hits[w])
					rec_next.way = way_width'(w);	// At most one way matches.
	end

	assign lru_update = tag_rec.req.valid && rec_next.hit;
	assign lru_set = tag_rec.req.address[set_index_width-1:0];
	assign lru_way = rec_next.way;

	always_ff @(posedge clk)
	begin
		if (reset)
			valid_q <= 1'b0;
		else if (!stall_pipeline)
			valid_q <= tag_rec.req.valid;
	end

	always_ff @(posedge clk)
	begin
		if (!stall_pipeline)
			rec_q <= rec_next;
	end

	always_comb
	begin
		match_rec = rec_q;
		match_rec.req.valid = valid_q;
	end

endmodule

// ==== rtl/l2_cache_pipe_pkg.sv ====
// ==========================================================
// Records carried between the pipeline stages.
// Each stage record keeps the whole request with it.
// ==========================================================
package l2_cache_pipe_pkg;
	import l2_cache_cfg_pkg::*;

	typedef struct packed
	{
		logic valid;
		logic [1:0] unit;
		logic [1:0] strand;
		logic [2:0] op;
		logic [addr_width-1:0] address;
		logic [line_bits-1:0] data;
		logic [line_bytes-1:0] mask;
		logic has_fill;	// Restarted with a fetched line.
		logic [way_width-1:0] fill_way;
		logic [line_bits-1:0] fill_data;
	} l2_request_t;

	typedef struct packed
	{
		l2_request_t req;
		logic [num_ways-1:0][tag_field_width-1:0] tags;
		logic [num_ways-1:0] way_valid;
		logic [way_width-1:0] replace_way;
	} l2_tag_rec_t;

	typedef struct packed
	{
		l2_request_t req;
		logic hit;	// Also set for a fill.
		logic [way_width-1:0] way;
		logic [way_width-1:0] replace_way;
	} l2_match_rec_t;

	typedef struct packed
	{
		logic valid;
		logic [1:0] unit;
		logic [1:0] strand;
		logic [2:0] op;
		logic [addr_width-1:0] address;
		logic hit;
		logic [way_width-1:0] way;
		logic [way_width-1:0] replace_way;
		logic [line_bits-1:0] data;
	} l2_response_t;

endpackage

// ==== rtl/l2_cache_response.sv ====
`timescale 1ns/1ps
// ==========================================================
// Response stage. A miss returns zero data and the way to
// replace. Valid is held off while the pipeline is stalled.
// ==========================================================
module l2_cache_response
	import l2_cache_cfg_pkg::*, l2_cache_pipe_pkg::*;
	(input logic clk,
	input logic reset,
	input logic stall_pipeline,
	input l2_match_rec_t data_rec,
	input logic [line_bits-1:0] line,
	output l2_response_t response);

	l2_response_t resp_next;
	logic valid_q;
	l2_response_t resp_q;

	always_comb
	begin
		resp_next.valid = data_rec.req.valid;
		resp_next.unit = data_rec.req.unit;
		resp_next.strand = data_rec.req.strand;
		resp_next.op = data_rec.req.op;
		resp_next.address = data_rec.req.address;
		resp_next.hit = data_rec.hit;
		resp_next.way = data_rec.way;
		resp_next.replace_way = data_rec.replace_way;
		resp_next.data = data_rec.hit ? line : '0;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			valid_q <= 1'b0;
		else if (!stall_pipeline)
			valid_q <= data_rec.req.valid;
	end

	always_ff @(posedge clk)
	begin
		if (!stall_pipeline)
			resp_q <= resp_next;
	end

	always_comb
	begin
		response = resp_q;
		response.valid = valid_q && !stall_pipeline;	// One strobe per request.
	end

endmodule

// ==== rtl/l2_cache_tag.sv ====
`timescale 1ns/1ps
// ==========================================================
// Tag stage. Reads four tags and valid bits for the set.
// A fill writes its tag in the same edge, so a request one
// cycle behind it already sees the new tag.
// ==========================================================
module l2_cache_tag
	import l2_cache_cfg_pkg::*, l2_cache_pipe_pkg::*;
	#(parameter int set_index_width = 6)
	(input logic clk,
	input logic reset,
	input logic stall_pipeline,
	input l2_request_t request,
	input logic [way_width-1:0] lru_way,
	output logic [set_index_width-1:0] lru_set,
	output l2_tag_rec_t tag_rec);

	localparam int num_sets = 1 << set_index_width;

	logic [tag_field_width-1:0] tag_mem [num_sets][num_ways];
	logic [num_sets-1:0][num_ways-1:0] valid_mem;
	logic [set_index_width-1:0] set;
	logic [tag_field_width-1:0] tag;
	logic [way_width-1:0] replace_way;
	logic fill;
	logic valid_q;
	l2_tag_rec_t rec_q;

	assign set = request.address[set_index_width-1:0];
	assign tag = request.address >> set_index_width;
	assign fill = request.valid && request.has_fill;
	assign lru_set = set;

	// An empty way wins over the pLRU choice, lowest first.
	always_comb
	begin
		replace_way = lru_way;
		for (int w = num_ways - 1; w >= 0; w--)
			if (!valid_mem[set][w])
				replace_way = way_width'(w);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			valid_q <= 1'b0;
			valid_mem <= '0;
		end
		else if (!stall_pipeline)
		begin
			valid_q <= request.valid;
			if (fill)
				valid_mem[set][request.fill_way] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!stall_pipeline)
		begin
			rec_q.req <= request;
			rec_q.way_valid <= valid_mem[set];
			rec_q.replace_way <= replace_way;
			for (int w = 0; w < num_ways; w++)
				rec_q.tags[w] <= tag_mem[set][w];
			if (fill)
				tag_mem[set][request.fill_way] <= tag;
		end
	end

	always_comb
	begin
		tag_rec = rec_q;
		tag_rec.req.valid = valid_q;
	end

endmodule

// ==== rtl/l2_cache_top.sv ====
`timescale 1ns/1ps
// ==========================================================
// L2 cache tag and data pipeline, four stages.
// Latency is four cycles plus one per stalled cycle.
// The sender holds its request while stall_pipeline is high.
// ==========================================================
module l2_cache_top
	import l2_cache_cfg_pkg::*, l2_cache_pipe_pkg::*;
	#(parameter int set_index_width = 6)
	(input logic clk,
	input logic reset,
	input logic stall_pipeline,
	input l2_request_t request,
	output l2_response_t response);

	logic [way_width-1:0] lru_way;
	logic [set_index_width-1:0] lru_set;
	logic lru_update;
	logic [set_index_width-1:0] update_set;
	logic [way_width-1:0] update_way;
	l2_tag_rec_t tag_rec;
	l2_match_rec_t match_rec;
	l2_match_rec_t data_rec;
	logic [line_bits-1:0] line;

	l2_cache_lru #(.set_index_width(set_index_width)) u_lru(
		.clk(clk),
		.reset(reset),
		.stall_pipeline(stall_pipeline),
		.set(lru_set),
		.update(lru_update),
		.update_set(update_set),
		.update_way(update_way),
		.lru_way(lru_way));

	l2_cache_tag #(.set_index_width(set_index_width)) u_tag(
		.clk(clk),
		.reset(reset),
		.stall_pipeline(stall_pipeline),
		.request(request),
		.lru_way(lru_way),
		.lru_set(lru_set),
		.tag_rec(tag_rec));

	l2_cache_match #(.set_index_width(set_index_width)) u_match(
		.clk(clk),
		.reset(reset),
		.stall_pipeline(stall_pipeline),
		.tag_rec(tag_rec),
		.match_rec(match_rec),
		.lru_update(lru_update),
		.lru_set(update_set),
		.lru_way(update_way));

	l2_cache_data #(.set_index_width(set_index_width)) u_data(
		.clk(clk),
		.reset(reset),
		.stall_pipeline(stall_pipeline),
		.match_rec(match_rec),
		.fill_data(match_rec.req.fill_data),
		.data_rec(data_rec),
		.line(line));

	l2_cache_response u_response(
		.clk(clk),
		.reset(reset),
		.stall_pipeline(stall_pipeline),
		.data_rec(data_rec),
		.line(line),
		.response(response));

endmodule

// ==== sim/l2_cache_model.svh ====
// ==========================================================
// Reference model of tags, valid bits, pLRU bits and lines.
// Stepped once per accepted cycle, idle cycles included.
// Needs set_bits and both cache packages in the including scope.
// ==========================================================
`ifndef L2_CACHE_MODEL_SVH
`define L2_CACHE_MODEL_SVH

localparam int model_sets = 1 << set_bits;

logic [addr_width-1:0] m_tag [model_sets][num_ways];
bit m_valid [model_sets][num_ways];
logic [2:0] m_tree [model_sets];
logic [line_bits-1:0] m_line [model_sets][num_ways];
bit pend_update;	// LRU touch waiting for the next accepted cycle.
int pend_set;
int pend_way;

function automatic void clear_model();
	for (int s = 0; s < model_sets; s++)
	begin
		m_tree[s] = 3'b000;
		for (int w = 0; w < num_ways; w++)
			m_valid[s][w] = 1'b0;
	end
	pend_update = 1'b0;
endfunction

// Way holding the address, or -1.
function automatic int find_way(input logic [addr_width-1:0] address);
	int s;
	int found;
	s = int'(address[set_bits-1:0]);
	found = -1;
	for (int w = 0; w < num_ways; w++)
		if (m_valid[s][w] && m_tag[s][w] == (address >> set_bits))
			found = w;
	return found;
endfunction

function automatic l2_response_t predict_response(input l2_request_t req);
	l2_response_t r;
	int s;
	int way;
	int victim;
	logic [line_bits-1:0] line;
	r = '0;
	s = int'(req.address[set_bits-1:0]);
	if (req.valid)
	begin
		// Root bit picks the older pair, the pair bit the older way.
		victim = m_tree[s][0] ? 2 + int'(m_tree[s][2]) : int'(m_tree[s][1]);
		for (int w = num_ways - 1; w >= 0; w--)
			if (!m_valid[s][w])
				victim = w;	// Lowest empty way first.
		way = find_way(req.address);
		r.hit = req.has_fill || way >= 0;
		if (req.has_fill)
			way = int'(req.fill_way);
		else if (way < 0)
			way = 0;
		line = req.has_fill ? req.fill_data : m_line[s][way];
		for (int b = 0; b < line_bytes; b++)
			if (req.op == op_store && req.mask[b])
				line[b * 8 +: 8] = req.data[b * 8 +: 8];
		if (r.hit && (req.has_fill || req.op == op_store))
			m_line[s][way] = line;
		if (req.has_fill)
		begin
			m_tag[s][way] = req.address >> set_bits;
			m_valid[s][way] = 1'b1;
		end
		r.valid = 1'b1;
		r.unit = req.unit;
		r.strand = req.strand;
		r.op = req.op;
		r.address = req.address;
		r.way = 2'(way);
		r.replace_way = 2'(victim);
		r.data = r.hit ? line : '0;
	end
	// The previous request's touch lands after this lookup.
	if (pend_update)
	begin
		m_tree[pend_set][0] = (pend_way < 2);
		if (pend_way < 2)
			m_tree[pend_set][1] = (pend_way == 0);
		else
			m_tree[pend_set][2] = (pend_way == 2);
	end
	pend_update = req.valid && r.hit;
	pend_set = s;
	pend_way = int'(r.way);
	return r;
endfunction

`endif

// ==== sim/l2_cache_tb.sv ====
`timescale 1ns/1ps
// ==========================================================
// Testbench for the L2 cache pipeline. Inputs change 1 ns
// after the rising edge; responses are sampled on the falling
// edge and checked in order against the reference model.
// ==========================================================
module l2_cache_tb
	import l2_cache_cfg_pkg::*, l2_cache_pipe_pkg::*;
	();

	localparam int set_bits = 6;

	logic clk = 1'b0;
	logic reset;
	logic stall_pipeline;
	l2_request_t request;
	l2_response_t response;

	integer seed = 34379;
	int issued = 0;
	int cycles = 0;
	int mismatches = 0;
	int failures = 0;
	l2_response_t expected [$];
	l2_response_t head;

	`include "l2_cache_model.svh"

	l2_cache_top #(.set_index_width(set_bits)) u_l2_cache_top(
		.clk(clk),
		.reset(reset),
		.stall_pipeline(stall_pipeline),
		.request(request),
		.response(response));

	always #4 clk = ~clk;

	function automatic logic [line_bits-1:0] random_line();
		logic [line_bits-1:0] v;
		for (int i = 0; i < line_bits / 32; i++)
			v[i * 32 +: 32] = $random(seed);
		return v;
	endfunction

	function automatic l2_request_t new_request(input int tag, input int set, input logic [2:0] op);
		l2_request_t r;
		r = '0;
		r.valid = 1'b1;
		r.unit = 2'($random(seed));
		r.strand = 2'($random(seed));
		r.op = op;
		r.address = addr_width'((tag << set_bits) | set);
		if (op == op_store)
		begin
			r.data = random_line();
			r.mask = {$random(seed), $random(seed)};
		end
		return r;
	endfunction

	function automatic l2_request_t with_fill(input l2_request_t r, input int way);
		r.has_fill = 1'b1;
		r.fill_way = 2'(way);
		r.fill_data = random_line();
		return r;
	endfunction

	// Holds the request until a cycle without stall takes it.
	task automatic issue(input l2_request_t req, input bit stall_some);
		bit accepted;
		l2_response_t exp_resp;
		accepted = 1'b0;
		while (!accepted)
		begin
			request = req;
			stall_pipeline = stall_some && (($random(seed) & 3) == 0);
			if (!stall_pipeline)
			begin
				exp_resp = predict_response(req);
				if (req.valid)
					expected.push_back(exp_resp);
				accepted = 1'b1;
			end
			issued++;
			@(posedge clk);
			#1;
		end
	endtask

	task automatic idle(input int n);
		repeat (n)
			issue('0, 1'b0);
	endtask

	task automatic report_mismatch(input string name, input logic [line_bits-1:0] got,
		input logic [line_bits-1:0] exp);
		$display("MISMATCH at time %0t: response.%s got %0h expected %0h",
			$time, name, got, exp);
		mismatches++;
	endtask

	task automatic check_response(input l2_response_t got, input l2_response_t exp);
		if (got.unit !== exp.unit)
			report_mismatch("unit", got.unit, exp.unit);
		if (got.strand !== exp.strand)
			report_mismatch("strand", got.strand, exp.strand);
		if (got.op !== exp.op)
			report_mismatch("op", got.op, exp.op);
		if (got.address !== exp.address)
			report_mismatch("address", got.address, exp.address);
		if (got.hit !== exp.hit)
			report_mismatch("hit", got.hit, exp.hit);
		if (got.way !== exp.way)
			report_mismatch("way", got.way, exp.way);
		if (got.replace_way !== exp.replace_way)
			report_mismatch("replace_way", got.replace_way, exp.replace_way);
		if (got.data !== exp.data)
			report_mismatch("data", got.data, exp.data);
	endtask

	always @(negedge clk)
	begin
		if (!reset && response.valid)
		begin
			if (stall_pipeline)
			begin
				$display("Error at time %0t: response valid while stalled", $time);
				failures++;
			end
			if (expected.size() == 0)
			begin
				$display("Error at time %0t: response with none expected", $time);
				failures++;
			end
			else
			begin
				head = expected.pop_front();
				check_response(response, head);
			end
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > 2 * issued + 50)
		begin
			$display("Timeout after %0d cycles, %0d responses outstanding",
				cycles, expected.size());
			$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	initial
	begin
		int hit_order [4];
		l2_request_t r;
		int set;
		int tag;
		hit_order = '{12, 10, 13, 11};
		reset = 1'b1;
		stall_pipeline = 1'b0;
		request = '0;
		clear_model();
		repeat (3)
			@(posedge clk);
		#1;
		reset = 1'b0;

		// Cold miss, then set 3 filled way by way and read back.
		issue(new_request(5, 3, op_load), 1'b0);
		for (int w = 0; w < num_ways; w++)
			issue(with_fill(new_request(10 + w, 3, op_load), w), 1'b0);
		for (int w = 0; w < num_ways; w++)
			issue(new_request(10 + w, 3, op_load), 1'b0);

		issue(with_fill(new_request(20, 7, op_store), 0), 1'b0);	// Store fill.
		issue(new_request(20, 7, op_load), 1'b0);
		issue(new_request(11, 3, op_store), 1'b0);	// Store hit.
		issue(new_request(11, 3, op_load), 1'b0);
		idle(2);

		// Spaced hits so each LRU touch is seen, then a miss.
		for (int i = 0; i < 4; i++)
		begin
			issue(new_request(hit_order[i], 3, op_load), 1'b0);
			idle(2);
		end
		issue(new_request(30, 3, op_load), 1'b0);
		idle(2);

		// Random traffic over a few sets with stall pulses.
		for (int i = 0; i < 300; i++)
		begin
			set = $random(seed) & 3;
			tag = 40 + ($random(seed) & 7);
			r = new_request(tag, set, ($random(seed) & 1) ? op_store : op_load);
			if (($random(seed) & 7) == 0)
				r = '0;
			else if (find_way(r.address) < 0 && ($random(seed) & 1))
				r = with_fill(r, $random(seed) & 3);
			issue(r, 1'b1);
		end
		idle(8);

		if (expected.size() != 0)
		begin
			$display("Error: %0d expected responses never appeared", expected.size());
			failures++;
		end
		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule
